/* design/seq_addr_gen.sv */
`timescale 1ns/1ps

module seq_addr_gen #(
    parameter int HAS_BACKUP = 0
) (
    input  logic           CLK,
    input  logic           RSTL,
    input  logic           purge,
    input  seq_pkg::addr_t field,
    input  logic           we,
    input  logic           bak,
    output seq_pkg::addr_t addr
);

    seq_pkg::addr_t step_addr;
    seq_pkg::addr_t bak_q;
    logic           restore;

    // Bit 15 picks subtract, bits 14..0 are the step size
    always_comb
    begin
        if (field[15])
            step_addr = addr - {1'b0, field[14:0]};
        else
            step_addr = addr + {1'b0, field[14:0]};
    end

    // ------------------------------
    // One-level backup
    // ------------------------------
    if (HAS_BACKUP != 0)
    begin : g_bak
        always_ff @(posedge CLK or negedge RSTL)
        begin
            if (!RSTL)
                bak_q <= '0;
            else if (purge)
                bak_q <= '0;
            else if (bak && !we)
                bak_q <= (bak_q != '0) ? '0 : addr;
        end
    end
    else
    begin : g_no_bak
        assign bak_q = '0;
    end

    assign restore = !we && bak && (bak_q != '0);

    always_ff @(posedge CLK or negedge RSTL)
    begin
        if (!RSTL)
            addr <= '0;
        else if (purge)
            addr <= '0;
        else if (we)
            addr <= field;
        else if (restore)
            addr <= bak_q;
        else
            addr <= step_addr;
    end

    a_no_bak: assert property (@(posedge CLK) disable iff (!RSTL)
        (HAS_BACKUP != 0) || !bak)
        else $error("backup requested on a generator without backup");

endmodule

/* design/seq_buf_ctrl.sv */
`timescale 1ns/1ps

module seq_buf_ctrl (
    input  logic              CLK,
    input  logic              RSTL,
    input  logic              purge,
    input  seq_pkg::inst_t    qi,
    output seq_pkg::en_ctrl_t wbuf_en_ctrl,
    output seq_pkg::en_ctrl_t output_en_ctrl,
    output logic              wbuf_switch
);

    seq_pkg::en_ctrl_t wbuf_fld;
    seq_pkg::en_ctrl_t out_fld;

    // Load or accumulate, wraps at 64
    function automatic seq_pkg::en_ctrl_t acc_next(
        input seq_pkg::en_ctrl_t cur,
        input seq_pkg::en_ctrl_t fld,
        input logic              load
    );
        return load ? fld : seq_pkg::en_ctrl_t'(cur + fld);
    endfunction

    assign wbuf_fld = qi[seq_pkg::F_WBUF_CTRL.lo +: $bits(seq_pkg::en_ctrl_t)];
    assign out_fld  = qi[seq_pkg::F_OUT_CTRL.lo +: $bits(seq_pkg::en_ctrl_t)];

    always_ff @(posedge CLK or negedge RSTL)
    begin
        if (!RSTL)
        begin
            wbuf_en_ctrl   <= '0;
            output_en_ctrl <= '0;
            wbuf_switch    <= 1'b0;
        end
        else if (purge)
        begin
            wbuf_en_ctrl   <= '0;
            output_en_ctrl <= '0;
            wbuf_switch    <= 1'b0;
        end
        else
        begin
            wbuf_en_ctrl   <= acc_next(wbuf_en_ctrl, wbuf_fld,
                                       qi[seq_pkg::F_WBUF_CTRL_WE.lo]);
            output_en_ctrl <= acc_next(output_en_ctrl, out_fld,
                                       qi[seq_pkg::F_OUT_CTRL_WE.lo]);
            // Bank flip for the weight buffer
            if (qi[seq_pkg::F_SWITCH.lo])
                wbuf_switch <= ~wbuf_switch;
        end
    end

endmodule

/* design/seq_loop_counters.sv */
`timescale 1ns/1ps

module seq_loop_counters (
    input  logic                             CLK,
    input  logic                             RSTL,
    input  logic                             purge,
    input  seq_pkg::inst_t                   qi,
    output logic [seq_pkg::N_COUNTERS-1:0]   last
);

    for (genvar i = 0; i < seq_pkg::N_COUNTERS; i++)
    begin : g_cnt
        // Count fields are not assumed contiguous
        localparam int LO = (i == 0) ? seq_pkg::F_CNT0.lo :
                            (i == 1) ? seq_pkg::F_CNT1.lo :
                            (i == 2) ? seq_pkg::F_CNT2.lo :
                                       seq_pkg::F_CNT3.lo;

        seq_pkg::count_t cnt;
        logic            we;
        logic            dec;

        assign we  = qi[seq_pkg::F_CNT_WE.lo + i];
        assign dec = qi[seq_pkg::F_JUMP.lo + i];

        always_ff @(posedge CLK or negedge RSTL)
        begin
            if (!RSTL)
                cnt <= '0;
            else if (purge)
                cnt <= '0;
            else if (we)
            begin
                // Load only once the previous loop has drained
                if (cnt == '0)
                    cnt <= qi[LO +: $bits(seq_pkg::count_t)];
            end
            else if (dec)
                cnt <= cnt - 1'b1;
        end

        assign last[i] = (cnt == seq_pkg::count_t'(1));
    end

endmodule

/* design/seq_out_stage.sv */
`timescale 1ns/1ps

module seq_out_stage (
    input  logic              CLK,
    input  logic              RSTL,
    input  logic              purge,
    input  seq_pkg::inst_t    qi,
    seq_state_if.stage        st,
    output seq_pkg::addr_t    raddr_x,
    output seq_pkg::addr_t    raddr_w,
    output seq_pkg::addr_t    waddr_x,
    output seq_pkg::en_ctrl_t wbuf_en_ctrl,
    output seq_pkg::en_ctrl_t output_en_ctrl,
    output logic              wbuf_switch,
    output seq_pkg::ctrl_t    ctrl
);

    // Freeze everything while a purge is in progress
    always_ff @(posedge CLK or negedge RSTL)
    begin
        if (!RSTL)
        begin
            raddr_x        <= '0;
            raddr_w        <= '0;
            waddr_x        <= '0;
            wbuf_en_ctrl   <= '0;
            output_en_ctrl <= '0;
            wbuf_switch    <= 1'b0;
            ctrl           <= '0;
        end
        else if (!purge)
        begin
            raddr_x        <= st.raddr_x;
            raddr_w        <= st.raddr_w;
            waddr_x        <= st.waddr_x;
            wbuf_en_ctrl   <= st.wbuf_en_ctrl;
            output_en_ctrl <= st.output_en_ctrl;
            wbuf_switch    <= st.wbuf_switch;
            ctrl           <= qi[seq_pkg::F_CTRL.lo +: $bits(seq_pkg::ctrl_t)];
        end
    end

    a_ctrl_hold: assert property (@(posedge CLK) disable iff (!RSTL)
        purge |=> $stable(ctrl))
        else $error("ctrl changed across a purge cycle");

endmodule

/* design/seq_pc.sv */
`timescale 1ns/1ps

module seq_pc (
    input  logic                             CLK,
    input  logic                             RSTL,
    input  logic                             purge,
    input  seq_pkg::inst_t                   qi,
    input  logic                             mbusy_w,
    input  logic                             mbusy_xi,
    input  logic                             mbusy_xo,
    input  logic [seq_pkg::N_COUNTERS-1:0]   last,
    output seq_pkg::pc_t                     pc
);

    logic [seq_pkg::N_COUNTERS-1:0] jump;
    logic [2:0]                     wait_bits;
    logic                           stall;
    logic                           take_jump;

    assign jump      = qi[seq_pkg::F_JUMP.lo +: seq_pkg::N_COUNTERS];
    assign wait_bits = qi[seq_pkg::F_WAIT.lo +: 3];

    // Any waited-on memory still busy means refetch
    assign stall = |(wait_bits & {mbusy_xo, mbusy_xi, mbusy_w});

    // Branch back unless the selected counter is on its last pass
    always_comb
    begin
        case (jump)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: take_jump = ~|(jump & last);
            default:                            take_jump = 1'b0;
        endcase
    end

    always_ff @(posedge CLK or negedge RSTL)
    begin
        if (!RSTL)
            pc <= '0;
        else if (purge)
            pc <= '0;
        else if (stall)
            pc <= pc - 1'b1;
        else if (take_jump)
            pc <= qi[seq_pkg::F_PC_TGT.lo +: $bits(seq_pkg::pc_t)];
        else
            pc <= pc + 1'b1;
    end

    a_jump_onehot: assert property (@(posedge CLK) disable iff (!RSTL)
        $onehot0(jump))
        else $error("jump field selects more than one counter");

endmodule

/* design/seq_pkg.sv */
package seq_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int INST_W     = 192;
    localparam int N_COUNTERS = 4;

    typedef logic [INST_W-1:0] inst_t;
    typedef logic [15:0]       pc_t;
    typedef logic [15:0]       addr_t;
    typedef logic [15:0]       count_t;
    typedef logic [5:0]        en_ctrl_t;
    typedef logic [15:0]       ctrl_t;

    // Low bit and width of one field
    typedef struct packed {
        int lo;
        int w;
    } field_t;

    // ------------------------------
    // Instruction layout
    // ------------------------------
    localparam field_t F_JUMP         = '{lo: 0,   w: 4};
    localparam field_t F_CNT_WE       = '{lo: 4,   w: 4};
    localparam field_t F_CNT0         = '{lo: 8,   w: 16};
    localparam field_t F_CNT1         = '{lo: 24,  w: 16};
    localparam field_t F_CNT2         = '{lo: 40,  w: 16};
    localparam field_t F_CNT3         = '{lo: 56,  w: 16};
    localparam field_t F_PC_TGT       = '{lo: 72,  w: 16};
    // Bit 0 waits on w, bit 1 on xi, bit 2 on xo
    localparam field_t F_WAIT         = '{lo: 88,  w: 3};
    localparam field_t F_RADDRX       = '{lo: 96,  w: 16};
    localparam field_t F_RADDRW       = '{lo: 112, w: 16};
    localparam field_t F_WADDRX       = '{lo: 128, w: 16};
    localparam field_t F_RADDRX_WE    = '{lo: 144, w: 1};
    localparam field_t F_RADDRW_WE    = '{lo: 145, w: 1};
    localparam field_t F_WADDRX_WE    = '{lo: 146, w: 1};
    localparam field_t F_RADDRX_BAK   = '{lo: 147, w: 1};
    localparam field_t F_RADDRW_BAK   = '{lo: 148, w: 1};
    localparam field_t F_WBUF_CTRL    = '{lo: 152, w: 6};
    localparam field_t F_OUT_CTRL     = '{lo: 160, w: 6};
    localparam field_t F_WBUF_CTRL_WE = '{lo: 166, w: 1};
    localparam field_t F_OUT_CTRL_WE  = '{lo: 167, w: 1};
    localparam field_t F_SWITCH       = '{lo: 168, w: 1};
    localparam field_t F_CTRL         = '{lo: 176, w: 16};

    // ------------------------------
    // Bits of the control field
    // ------------------------------
    localparam field_t C_BANKX   = '{lo: 0,  w: 1};
    localparam field_t C_BANKW   = '{lo: 1,  w: 1};
    localparam field_t C_RCEBX   = '{lo: 2,  w: 1};
    localparam field_t C_WCEBX   = '{lo: 3,  w: 1};
    localparam field_t C_RCEBW   = '{lo: 4,  w: 1};
    localparam field_t C_REQW    = '{lo: 5,  w: 1};
    localparam field_t C_WBUF_EN = '{lo: 6,  w: 1};
    localparam field_t C_MAC_EN  = '{lo: 7,  w: 1};
    localparam field_t C_NL_EN   = '{lo: 8,  w: 1};
    localparam field_t C_SEQ_FIN = '{lo: 9,  w: 1};
    localparam field_t C_NL_SEL  = '{lo: 10, w: 2};
    localparam field_t C_OLSB    = '{lo: 12, w: 4};

endpackage

/* design/seq_state_if.sv */
`timescale 1ns/1ps

// Sequencer state on its way to the output stage
interface seq_state_if;

    seq_pkg::addr_t    raddr_x;
    seq_pkg::addr_t    raddr_w;
    seq_pkg::addr_t    waddr_x;
    seq_pkg::en_ctrl_t wbuf_en_ctrl;
    seq_pkg::en_ctrl_t output_en_ctrl;
    logic              wbuf_switch;

    modport src (
        output raddr_x, raddr_w, waddr_x,
        output wbuf_en_ctrl, output_en_ctrl, wbuf_switch
    );

    modport stage (
        input raddr_x, raddr_w, waddr_x,
        input wbuf_en_ctrl, output_en_ctrl, wbuf_switch
    );

endinterface

/* design/seq_top.sv */
`timescale 1ns/1ps

module seq_top (
    input  logic              CLK,
    input  logic              RSTL,
    input  logic              purge,
    input  logic              mbusy_w,
    input  logic              mbusy_xi,
    input  logic              mbusy_xo,
    input  seq_pkg::inst_t    qi,
    output seq_pkg::pc_t      raddr_i,
    output seq_pkg::addr_t    raddr_x,
    output seq_pkg::addr_t    raddr_w,
    output seq_pkg::addr_t    waddr_x,
    output seq_pkg::en_ctrl_t wbuf_en_ctrl,
    output seq_pkg::en_ctrl_t output_en_ctrl,
    output logic              wbuf_switch,
    output seq_pkg::ctrl_t    ctrl
);

    logic [seq_pkg::N_COUNTERS-1:0] last;

    seq_state_if u_state ();

    // ------------------------------
    // Program flow
    // ------------------------------
    seq_loop_counters u_loop (
        .CLK(CLK), .RSTL(RSTL), .purge(purge), .qi(qi), .last(last)
    );

    seq_pc u_pc (
        .CLK(CLK), .RSTL(RSTL), .purge(purge), .qi(qi),
        .mbusy_w(mbusy_w), .mbusy_xi(mbusy_xi), .mbusy_xo(mbusy_xo),
        .last(last), .pc(raddr_i)
    );

    // ------------------------------
    // Data-memory addresses
    // ------------------------------
    seq_addr_gen #(.HAS_BACKUP(1)) u_raddr_x (
        .CLK(CLK), .RSTL(RSTL), .purge(purge),
        .field(qi[seq_pkg::F_RADDRX.lo +: $bits(seq_pkg::addr_t)]),
        .we(qi[seq_pkg::F_RADDRX_WE.lo]), .bak(qi[seq_pkg::F_RADDRX_BAK.lo]),
        .addr(u_state.raddr_x)
    );

    seq_addr_gen #(.HAS_BACKUP(1)) u_raddr_w (
        .CLK(CLK), .RSTL(RSTL), .purge(purge),
        .field(qi[seq_pkg::F_RADDRW.lo +: $bits(seq_pkg::addr_t)]),
        .we(qi[seq_pkg::F_RADDRW_WE.lo]), .bak(qi[seq_pkg::F_RADDRW_BAK.lo]),
        .addr(u_state.raddr_w)
    );

    // Write side never saves its address
    seq_addr_gen #(.HAS_BACKUP(0)) u_waddr_x (
        .CLK(CLK), .RSTL(RSTL), .purge(purge),
        .field(qi[seq_pkg::F_WADDRX.lo +: $bits(seq_pkg::addr_t)]),
        .we(qi[seq_pkg::F_WADDRX_WE.lo]), .bak(1'b0),
        .addr(u_state.waddr_x)
    );

    seq_buf_ctrl u_buf (
        .CLK(CLK), .RSTL(RSTL), .purge(purge), .qi(qi),
        .wbuf_en_ctrl(u_state.wbuf_en_ctrl),
        .output_en_ctrl(u_state.output_en_ctrl),
        .wbuf_switch(u_state.wbuf_switch)
    );

    seq_out_stage u_out (
        .CLK(CLK), .RSTL(RSTL), .purge(purge), .qi(qi), .st(u_state.stage),
        .raddr_x(raddr_x), .raddr_w(raddr_w), .waddr_x(waddr_x),
        .wbuf_en_ctrl(wbuf_en_ctrl), .output_en_ctrl(output_en_ctrl),
        .wbuf_switch(wbuf_switch), .ctrl(ctrl)
    );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the sequencer testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top -f sources.f -Mdir "$BUILD_DIR" -o tb_top_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_top_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* sources.f */
design/seq_pkg.sv
design/seq_state_if.sv
design/seq_pc.sv
design/seq_loop_counters.sv
design/seq_addr_gen.sv
design/seq_buf_ctrl.sv
design/seq_out_stage.sv
design/seq_top.sv
testbench/tb_clock.sv
testbench/tb_top.sv

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 16
) (
    output logic CLK,
    output logic RSTL
);

    initial
    begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    // Release lands on a rising edge, after the flops have sampled reset
    initial
    begin
        RSTL = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        RSTL <= 1'b1;
    end

endmodule

/* testbench/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    localparam int PROG_DEPTH      = 64;
    localparam int PROG_LEN        = 18;
    localparam int SEED            = 66344;
    localparam int LOOP_OUTER      = 3;
    localparam int LOOP_INNER      = 4;
    localparam int BUSY_WINDOW     = 24;
    localparam int PURGE_CYCLES    = PROG_LEN * 6;
    localparam int WATCHDOG_CYCLES = PROG_LEN * 40;

    // Mirror of every sequencer register, o_ marks the output stage
    typedef struct packed {
        seq_pkg::pc_t                           pc;
        logic [seq_pkg::N_COUNTERS-1:0][15:0]   cnt;
        seq_pkg::addr_t                         rx;
        seq_pkg::addr_t                         rw;
        seq_pkg::addr_t                         wx;
        seq_pkg::addr_t                         bak_x;
        seq_pkg::addr_t                         bak_w;
        seq_pkg::en_ctrl_t                      wbuf;
        seq_pkg::en_ctrl_t                      outc;
        logic                                   sw;
        seq_pkg::addr_t                         o_rx;
        seq_pkg::addr_t                         o_rw;
        seq_pkg::addr_t                         o_wx;
        seq_pkg::en_ctrl_t                      o_wbuf;
        seq_pkg::en_ctrl_t                      o_outc;
        logic                                   o_sw;
        seq_pkg::ctrl_t                         o_ctrl;
    } model_t;

    logic              CLK;
    logic              RSTL;
    seq_pkg::inst_t    qi = '0;
    logic              purge;
    logic              mbusy_w;
    logic              mbusy_xi;
    logic              mbusy_xo;
    seq_pkg::pc_t      raddr_i;
    seq_pkg::addr_t    raddr_x;
    seq_pkg::addr_t    raddr_w;
    seq_pkg::addr_t    waddr_x;
    seq_pkg::en_ctrl_t wbuf_en_ctrl;
    seq_pkg::en_ctrl_t output_en_ctrl;
    logic              wbuf_switch;
    seq_pkg::ctrl_t    ctrl;

    seq_pkg::inst_t prog [0:PROG_DEPTH-1];
    model_t         model = '0;
    int             n_mismatch = 0;
    int             n_other = 0;

    tb_clock u_clk (.CLK(CLK), .RSTL(RSTL));

    seq_top u_seq_top (
        .CLK(CLK), .RSTL(RSTL), .purge(purge),
        .mbusy_w(mbusy_w), .mbusy_xi(mbusy_xi), .mbusy_xo(mbusy_xo), .qi(qi),
        .raddr_i(raddr_i), .raddr_x(raddr_x), .raddr_w(raddr_w), .waddr_x(waddr_x),
        .wbuf_en_ctrl(wbuf_en_ctrl), .output_en_ctrl(output_en_ctrl),
        .wbuf_switch(wbuf_switch), .ctrl(ctrl)
    );

    // ------------------------------
    // Field access
    // ------------------------------
    function automatic logic [31:0] get_field(input seq_pkg::inst_t q,
                                              input seq_pkg::field_t f);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < f.w; i++)
            v[i] = q[f.lo + i];
        return v;
    endfunction

    function automatic seq_pkg::field_t ctrl_field(input seq_pkg::field_t c);
        seq_pkg::field_t f;
        f.lo = seq_pkg::F_CTRL.lo + c.lo;
        f.w  = c.w;
        return f;
    endfunction

    function automatic seq_pkg::field_t cnt_field(input int i);
        case (i)
            0:       return seq_pkg::F_CNT0;
            1:       return seq_pkg::F_CNT1;
            2:       return seq_pkg::F_CNT2;
            default: return seq_pkg::F_CNT3;
        endcase
    endfunction

    task automatic put(input int a, input seq_pkg::field_t f, input logic [31:0] v);
        int i;
        for (i = 0; i < f.w; i++)
            prog[a][f.lo + i] = v[i];
    endtask

    // Addresses past the program read as NOPs
    function automatic seq_pkg::inst_t fetch(input seq_pkg::pc_t a);
        return (a < PROG_DEPTH) ? prog[a] : '0;
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic seq_pkg::addr_t addr_step(input seq_pkg::addr_t cur,
                                                 input seq_pkg::addr_t fld);
        seq_pkg::addr_t mag;
        mag = {1'b0, fld[14:0]};
        return fld[15] ? cur - mag : cur + mag;
    endfunction

    // Returns {backup, address}
    function automatic logic [31:0] backup_gen(input seq_pkg::addr_t cur,
                                               input seq_pkg::addr_t saved,
                                               input seq_pkg::addr_t fld,
                                               input logic we,
                                               input logic bak);
        if (we)
            return {saved, fld};
        if (bak && saved != '0)
            return {16'h0000, saved};
        if (bak)
            return {cur, addr_step(cur, fld)};
        return {saved, addr_step(cur, fld)};
    endfunction

    function automatic model_t ref_next(input model_t s, input seq_pkg::inst_t q,
                                        input logic prg, input logic bw,
                                        input logic bxi, input logic bxo);
        model_t     n;
        logic [3:0] jmp;
        logic [3:0] cwe;
        logic [2:0] wt;
        logic       hit_last;
        int         i;
        n   = s;
        jmp = 4'(get_field(q, seq_pkg::F_JUMP));
        cwe = 4'(get_field(q, seq_pkg::F_CNT_WE));
        wt  = 3'(get_field(q, seq_pkg::F_WAIT));
        if (prg)
        begin
            // State clears, registered outputs keep their values
            n.pc    = '0;
            n.cnt   = '0;
            n.rx    = '0;
            n.rw    = '0;
            n.wx    = '0;
            n.bak_x = '0;
            n.bak_w = '0;
            n.wbuf  = '0;
            n.outc  = '0;
            n.sw    = 1'b0;
        end
        else
        begin
            n.o_rx   = s.rx;
            n.o_rw   = s.rw;
            n.o_wx   = s.wx;
            n.o_wbuf = s.wbuf;
            n.o_outc = s.outc;
            n.o_sw   = s.sw;
            n.o_ctrl = 16'(get_field(q, seq_pkg::F_CTRL));

            hit_last = 1'b0;
            for (i = 0; i < 4; i++)
            begin
                if (jmp[i] && s.cnt[i] == 16'd1)
                    hit_last = 1'b1;
            end
            if ((wt[0] && bw) || (wt[1] && bxi) || (wt[2] && bxo))
                n.pc = s.pc - 16'd1;
            else if ($countones(jmp) == 1 && !hit_last)
                n.pc = 16'(get_field(q, seq_pkg::F_PC_TGT));
            else
                n.pc = s.pc + 16'd1;

            for (i = 0; i < 4; i++)
            begin
                if (cwe[i])
                begin
                    if (s.cnt[i] == '0)
                        n.cnt[i] = 16'(get_field(q, cnt_field(i)));
                end
                else if (jmp[i])
                    n.cnt[i] = s.cnt[i] - 16'd1;
            end

            {n.bak_x, n.rx} = backup_gen(s.rx, s.bak_x,
                16'(get_field(q, seq_pkg::F_RADDRX)),
                q[seq_pkg::F_RADDRX_WE.lo], q[seq_pkg::F_RADDRX_BAK.lo]);
            {n.bak_w, n.rw} = backup_gen(s.rw, s.bak_w,
                16'(get_field(q, seq_pkg::F_RADDRW)),
                q[seq_pkg::F_RADDRW_WE.lo], q[seq_pkg::F_RADDRW_BAK.lo]);
            if (q[seq_pkg::F_WADDRX_WE.lo])
                n.wx = 16'(get_field(q, seq_pkg::F_WADDRX));
            else
                n.wx = addr_step(s.wx, 16'(get_field(q, seq_pkg::F_WADDRX)));

            n.wbuf = q[seq_pkg::F_WBUF_CTRL_WE.lo] ? 6'(get_field(q, seq_pkg::F_WBUF_CTRL))
                   : 6'(s.wbuf + 6'(get_field(q, seq_pkg::F_WBUF_CTRL)));
            n.outc = q[seq_pkg::F_OUT_CTRL_WE.lo] ? 6'(get_field(q, seq_pkg::F_OUT_CTRL))
                   : 6'(s.outc + 6'(get_field(q, seq_pkg::F_OUT_CTRL)));
            n.sw   = s.sw ^ q[seq_pkg::F_SWITCH.lo];
        end
        return n;
    endfunction

    // ------------------------------
    // Program
    // ------------------------------
    task automatic build_program();
        int a;
        for (a = 0; a < PROG_DEPTH; a++)
            prog[a] = '0;
        // Setup loads
        put(1, seq_pkg::F_RADDRX, 16'h0100);
        put(1, seq_pkg::F_RADDRX_WE, 1);
        put(1, seq_pkg::F_RADDRW, 16'h0200);
        put(1, seq_pkg::F_RADDRW_WE, 1);
        put(1, seq_pkg::F_WADDRX, 16'h0300);
        put(1, seq_pkg::F_WADDRX_WE, 1);
        put(1, seq_pkg::F_WBUF_CTRL, 5);
        put(1, seq_pkg::F_WBUF_CTRL_WE, 1);
        put(1, seq_pkg::F_OUT_CTRL, 60);
        put(1, seq_pkg::F_OUT_CTRL_WE, 1);
        put(1, ctrl_field(seq_pkg::C_BANKX), 1);
        put(1, ctrl_field(seq_pkg::C_RCEBX), 1);
        // Waits, each followed by a NOP slot
        put(2, seq_pkg::F_WAIT, 3'b001);
        put(2, ctrl_field(seq_pkg::C_REQW), 1);
        put(4, seq_pkg::F_WAIT, 3'b110);
        put(4, ctrl_field(seq_pkg::C_WBUF_EN), 1);
        // Steps, save, restore
        put(6, seq_pkg::F_RADDRX, 16'h0004);
        put(6, seq_pkg::F_RADDRW, 16'h8003);
        put(6, seq_pkg::F_WADDRX, 16'h0001);
        put(6, ctrl_field(seq_pkg::C_NL_SEL), 2);
        put(7, seq_pkg::F_RADDRX_BAK, 1);
        put(7, seq_pkg::F_RADDRX, 16'h0002);
        put(7, seq_pkg::F_RADDRW_BAK, 1);
        put(7, seq_pkg::F_RADDRW, 16'h0001);
        put(7, seq_pkg::F_WBUF_CTRL, 30);
        put(7, seq_pkg::F_OUT_CTRL, 7);
        put(7, seq_pkg::F_SWITCH, 1);
        put(8, seq_pkg::F_RADDRX, 16'h0008);
        put(8, seq_pkg::F_RADDRW, 16'h8010);
        put(8, seq_pkg::F_SWITCH, 1);
        put(8, ctrl_field(seq_pkg::C_OLSB), 4'hA);
        put(9, seq_pkg::F_RADDRX_BAK, 1);
        put(9, seq_pkg::F_RADDRW_BAK, 1);
        put(9, seq_pkg::F_WBUF_CTRL, 40);
        // Outer loop on counter 0, inner on counter 1
        put(10, seq_pkg::F_CNT_WE, 4'b0001);
        put(10, seq_pkg::F_CNT0, LOOP_OUTER);
        put(11, seq_pkg::F_CNT_WE, 4'b0010);
        put(11, seq_pkg::F_CNT1, LOOP_INNER);
        put(11, seq_pkg::F_WADDRX, 1);
        put(12, ctrl_field(seq_pkg::C_MAC_EN), 1);
        put(12, seq_pkg::F_RADDRX, 1);
        put(13, seq_pkg::F_JUMP, 4'b0010);
        put(13, seq_pkg::F_PC_TGT, 12);
        put(15, seq_pkg::F_JUMP, 4'b0001);
        put(15, seq_pkg::F_PC_TGT, 11);
        put(15, ctrl_field(seq_pkg::C_NL_EN), 1);
        put(17, ctrl_field(seq_pkg::C_SEQ_FIN), 1);
    endtask

    // ------------------------------
    // Checks and run control
    // ------------------------------
    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
        assert (got === exp)
        else
        begin
            n_mismatch++;
            $display("MISMATCH %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d mismatches, %0d other errors", n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    endtask

    // Two purge cycles flush the fetched word, then run until SEQ_FIN shows
    task automatic run_program(input logic busy_on, output int macs, output int backs);
        seq_pkg::pc_t prev_pc;
        int           cycle;
        macs    = 0;
        backs   = 0;
        cycle   = 0;
        prev_pc = '0;
        @(posedge CLK);
        purge    <= 1'b1;
        mbusy_w  <= 1'b0;
        mbusy_xi <= 1'b0;
        mbusy_xo <= 1'b0;
        repeat (2) @(posedge CLK);
        purge <= 1'b0;
        do
        begin
            @(posedge CLK);
            mbusy_w  <= busy_on && cycle < BUSY_WINDOW && ($urandom % 4 != 0);
            mbusy_xi <= busy_on && cycle < BUSY_WINDOW && ($urandom % 4 != 0);
            mbusy_xo <= busy_on && cycle < BUSY_WINDOW && ($urandom % 4 != 0);
            cycle++;
            @(negedge CLK);
            if (ctrl[seq_pkg::C_MAC_EN.lo])
                macs++;
            if (raddr_i == prev_pc - 16'd1)
                backs++;
            prev_pc = raddr_i;
        end
        while (!ctrl[seq_pkg::C_SEQ_FIN.lo]);
    endtask

    always @(posedge CLK)
    begin
        qi <= fetch(raddr_i);
    end

    always @(posedge CLK or negedge RSTL)
    begin
        if (!RSTL)
            model = '0;
        else
            model = ref_next(model, qi, purge, mbusy_w, mbusy_xi, mbusy_xo);
    end

    always @(negedge CLK)
    begin
        compare_value("raddr_i", raddr_i, model.pc);
        compare_value("raddr_x", raddr_x, model.o_rx);
        compare_value("raddr_w", raddr_w, model.o_rw);
        compare_value("waddr_x", waddr_x, model.o_wx);
        compare_value("wbuf_en_ctrl", 16'(wbuf_en_ctrl), 16'(model.o_wbuf));
        compare_value("output_en_ctrl", 16'(output_en_ctrl), 16'(model.o_outc));
        compare_value("wbuf_switch", 16'(wbuf_switch), 16'(model.o_sw));
        compare_value("ctrl", ctrl, model.o_ctrl);
    end

    initial
    begin
        int macs;
        int backs;
        void'($urandom(SEED));
        purge    = 1'b0;
        mbusy_w  = 1'b0;
        mbusy_xi = 1'b0;
        mbusy_xo = 1'b0;
        build_program();
        @(posedge RSTL);

        // Quiet memories
        run_program(1'b0, macs, backs);
        compare_value("mac_en cycles, quiet run", 16'(macs), 16'(LOOP_OUTER * LOOP_INNER));
        assert (backs == 0)
        else
        begin
            n_other++;
            $display("raddr_i stepped back although no memory was busy");
        end

        // Random busy at the start of the run
        run_program(1'b1, macs, backs);
        compare_value("mac_en cycles, busy run", 16'(macs), 16'(LOOP_OUTER * LOOP_INNER));
        assert (backs > 0)
        else
        begin
            n_other++;
            $display("raddr_i never stepped back while the memories were busy");
        end

        // Random purge pulses anywhere in the program
        repeat (PURGE_CYCLES)
        begin
            @(posedge CLK);
            purge    <= ($urandom % 12 == 0);
            mbusy_w  <= $urandom % 2;
            mbusy_xi <= $urandom % 2;
            mbusy_xo <= $urandom % 2;
        end
        run_program(1'b0, macs, backs);
        compare_value("mac_en cycles, after purges", 16'(macs),
                      16'(LOOP_OUTER * LOOP_INNER));
        finish_run();
    end

    initial
    begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        n_other++;
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        finish_run();
    end

endmodule
